/* verilog/pmp_pkg.sv */
//**************************************************************************
// Shared PMP types for an RV32 core. Grain is fixed at 4 bytes, so pmpaddr
// values hold word addresses and NA4 is always available
//**************************************************************************
package pmp_pkg;

  localparam int unsigned PMP_ENTRIES   = 16;
  localparam logic [11:0] PMP_CFG_BASE  = 12'h3A0;  // pmpcfg0..3
  localparam logic [11:0] PMP_ADDR_BASE = 12'h3B0;  // pmpaddr0..15

  // Privilege level encoding used by mstatus.MPP
  localparam logic [1:0]  PRIV_M        = 2'b11;

  typedef enum logic [1:0] {
    OFF   = 2'b00,
    TOR   = 2'b01,
    NA4   = 2'b10,
    NAPOT = 2'b11
  } pmp_mode_e;

  // One pmpcfg byte with L in the MSB
  typedef struct packed {
    logic       L;
    logic [1:0] reserved;   // Always reads zero
    pmp_mode_e  A;
    logic       X;
    logic       W;
    logic       R;
  } pmpcfg_t;

  typedef pmpcfg_t [PMP_ENTRIES-1:0]          pmp_cfg_array_t;
  typedef logic    [PMP_ENTRIES-1:0][31:0]    pmp_addr_array_t;

  // CSR write data seen as four cfg bytes or as one pmpaddr value
  typedef union packed {
    pmpcfg_t [3:0] cfg;
    logic [31:0]   addr;
  } pmp_csr_word_u;

  typedef struct packed {
    logic          valid;
    logic          write;
    logic [11:0]   addr;
    pmp_csr_word_u wdata;
  } pmp_csr_req_t;

  typedef struct packed {
    logic       m_mode;  // Hart currently in M mode
    logic       mprv;
    logic [1:0] mpp;
  } pmp_priv_t;

  typedef struct packed {
    logic [31:0] addr;   // Byte address
    logic        rd;
    logic        wr;
    logic        ex;
  } pmp_access_t;

  typedef struct packed {
    logic load;
    logic store;
    logic fetch;
  } pmp_fault_t;

endpackage

/* verilog/pmp_matcher.sv */
//**************************************************************************
// Region match for one PMP entry, on word addresses (4-byte grain)
//**************************************************************************
`timescale 1ns/10ps

module pmp_matcher import pmp_pkg::*; (
  input  logic [31:0] i_word_addr,   // Byte address >> 2
  input  pmpcfg_t     i_cfg,
  input  logic [31:0] i_addr,
  input  logic [31:0] i_prev_addr,   // pmpaddr of the entry below or zero for entry 0
  output logic        o_match
);

  logic [31:0] low_ones;    // Trailing ones of i_addr plus the first zero
  logic [31:0] napot_mask;  // Bits that take part in the NAPOT compare
  logic        tor_hit;
  logic        na4_hit;
  logic        napot_hit;

  // x ^ (x+1) sets bits 0..t where t is the trailing-ones count
  assign low_ones   = i_addr ^ (i_addr + 32'd1);
  assign napot_mask = ~low_ones;

  assign tor_hit   = (i_word_addr >= i_prev_addr) && (i_word_addr < i_addr);
  assign na4_hit   = (i_word_addr == i_addr);
  assign napot_hit = ((i_word_addr & napot_mask) == (i_addr & napot_mask));

  always_comb begin
    unique case (i_cfg.A)
      TOR:     o_match = tor_hit;
      NA4:     o_match = na4_hit;
      NAPOT:   o_match = napot_hit;   // 2^(t+3) byte region
      default: o_match = 1'b0;        // OFF
    endcase
  end

endmodule

/* verilog/pmp_checker.sv */
//**************************************************************************
// Checks one access against all entries, lowest index wins. IS_FETCH=1
// ignores MPRV, since MPRV only affects loads and stores
//**************************************************************************
`timescale 1ns/10ps

module pmp_checker import pmp_pkg::*; #(
  parameter bit IS_FETCH = 1'b0
) (
  input  pmp_access_t     i_access,
  input  pmp_priv_t       i_priv,
  input  pmp_cfg_array_t  i_cfg,
  input  pmp_addr_array_t i_addr,
  output pmp_fault_t      o_fault
);

  logic [31:0]            word_addr;
  logic [PMP_ENTRIES-1:0] match;
  logic                   hit;        // Some entry matched
  pmpcfg_t                hit_cfg;    // Config of the winning entry
  logic                   enforce;

  // One permission bit of the winning entry
  function automatic logic denied(logic enf, logic any_hit, logic lock, logic perm);
    if (enf) begin
      return !any_hit || !perm;
    end
    return any_hit && lock && !perm;  // M mode only bound by locked entries
  endfunction

  assign word_addr = {2'b00, i_access.addr[31:2]};

  for (genvar g = 0; g < PMP_ENTRIES; g++) begin : g_match
    logic [31:0] prev_addr;
    if (g == 0) begin : g_first
      assign prev_addr = '0;
    end else begin : g_rest
      assign prev_addr = i_addr[g-1];
    end

    pmp_matcher u_match (
      .i_word_addr (word_addr),
      .i_cfg       (i_cfg[g]),
      .i_addr      (i_addr[g]),
      .i_prev_addr (prev_addr),
      .o_match     (match[g])
    );
  end

  // Walk downwards so the lowest matching index is the one kept
  always_comb begin
    hit     = 1'b0;
    hit_cfg = '0;
    for (int k = PMP_ENTRIES - 1; k >= 0; k--) begin
      if (match[k]) begin
        hit     = 1'b1;
        hit_cfg = i_cfg[k];
      end
    end
  end

  assign enforce = !i_priv.m_mode ||
                   (!IS_FETCH && i_priv.mprv && (i_priv.mpp != PRIV_M));

  assign o_fault.load  = i_access.rd && denied(enforce, hit, hit_cfg.L, hit_cfg.R);
  assign o_fault.store = i_access.wr && denied(enforce, hit, hit_cfg.L, hit_cfg.W);
  assign o_fault.fetch = i_access.ex && denied(enforce, hit, hit_cfg.L, hit_cfg.X);

endmodule

/* verilog/pmp_csr_file.sv */
//**************************************************************************
// pmpcfg0..3 and pmpaddr0..15 storage. Writes follow the WARL and lock rules.
// Reads are combinational and return zero on a non-PMP address
//**************************************************************************
`timescale 1ns/10ps

module pmp_csr_file import pmp_pkg::*; (
  input  logic            CLK,
  input  logic            nRST,
  input  pmp_csr_req_t    i_csr,
  output logic [31:0]     o_csr_rdata,
  output logic            o_csr_hit,
  output pmp_cfg_array_t  o_cfg,
  output pmp_addr_array_t o_addr
);

  pmp_cfg_array_t   cfg_q;
  pmp_cfg_array_t   cfg_d;
  pmp_addr_array_t  addr_q;
  pmp_addr_array_t  addr_d;
  logic [3:0][31:0] cfg_words;   // Same bits grouped as pmpcfg CSRs
  logic             cfg_sel;
  logic             addr_sel;
  logic             csr_wr;
  logic [1:0]       cfg_idx;
  logic [3:0]       addr_idx;
  logic [3:0]       above_idx;   // Entry whose TOR range starts at addr_idx
  logic             above_tor_lock;

  // WARL filter for one cfg byte
  function automatic pmpcfg_t warl_cfg(pmpcfg_t wr_val, pmpcfg_t cur);
    pmpcfg_t res;
    res          = wr_val;
    res.reserved = 2'b00;
    if (!res.R) begin
      res.W = 1'b0;  // R=0/W=1 is reserved
    end
    if (cur.L) begin
      res = cur;     // Locked until reset
    end
    return res;
  endfunction

  assign cfg_sel   = (i_csr.addr[11:2] == PMP_CFG_BASE[11:2]);
  assign addr_sel  = (i_csr.addr[11:4] == PMP_ADDR_BASE[11:4]);
  assign cfg_idx   = i_csr.addr[1:0];
  assign addr_idx  = i_csr.addr[3:0];
  assign above_idx = addr_idx + 4'd1;
  assign csr_wr    = i_csr.valid & i_csr.write;

  // Last entry has nobody above it
  assign above_tor_lock = (addr_idx != 4'(PMP_ENTRIES - 1)) &&
                          cfg_q[above_idx].L && (cfg_q[above_idx].A == TOR);

  always_comb begin
    logic [3:0] ent;
    cfg_d  = cfg_q;
    addr_d = addr_q;
    ent    = '0;
    if (csr_wr && cfg_sel) begin
      for (int b = 0; b < 4; b++) begin
        ent        = {cfg_idx, 2'(b)};
        cfg_d[ent] = warl_cfg(i_csr.wdata.cfg[b], cfg_q[ent]);
      end
    end
    if (csr_wr && addr_sel && !cfg_q[addr_idx].L && !above_tor_lock) begin
      addr_d[addr_idx] = i_csr.wdata.addr;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cfg_q  <= '0;  // All entries OFF and unlocked
      addr_q <= '0;
    end else begin
      cfg_q  <= cfg_d;
      addr_q <= addr_d;
    end
  end

  assign cfg_words = cfg_q;
  assign o_csr_hit = cfg_sel | addr_sel;

  // Stored value is returned as is
  always_comb begin
    if (cfg_sel) begin
      o_csr_rdata = cfg_words[cfg_idx];
    end else if (addr_sel) begin
      o_csr_rdata = addr_q[addr_idx];
    end else begin
      o_csr_rdata = '0;
    end
  end

  assign o_cfg  = cfg_q;
  assign o_addr = addr_q;

endmodule

/* verilog/pmp_unit.sv */
//**************************************************************************
// PMP top. Data and fetch faults are reported independently and the core
// picks which one to raise. Results are combinational with no handshake
//**************************************************************************
`timescale 1ns/10ps

module pmp_unit import pmp_pkg::*; (
  input  logic         CLK,
  input  logic         nRST,
  input  pmp_csr_req_t i_csr,
  input  pmp_priv_t    i_priv,
  input  pmp_access_t  i_daccess,   // ex tied low by the core
  input  pmp_access_t  i_iaccess,   // Only ex is used
  output logic [31:0]  o_csr_rdata,
  output logic         o_csr_hit,
  output pmp_fault_t   o_dfault,
  output pmp_fault_t   o_ifault
);

  pmp_cfg_array_t  cfg;
  pmp_addr_array_t addr;

  pmp_csr_file u_csr (
    .CLK         (CLK),
    .nRST        (nRST),
    .i_csr       (i_csr),
    .o_csr_rdata (o_csr_rdata),
    .o_csr_hit   (o_csr_hit),
    .o_cfg       (cfg),
    .o_addr      (addr)
  );

  pmp_checker #(.IS_FETCH(1'b0)) u_dcheck (
    .i_access (i_daccess),
    .i_priv   (i_priv),
    .i_cfg    (cfg),
    .i_addr   (addr),
    .o_fault  (o_dfault)
  );

  pmp_checker #(.IS_FETCH(1'b1)) u_icheck (
    .i_access (i_iaccess),
    .i_priv   (i_priv),
    .i_cfg    (cfg),
    .i_addr   (addr),
    .o_fault  (o_ifault)
  );

endmodule

/* dv/pmp_tb_ref.svh */
//**************************************************************************
// Reference model for the PMP testbench. Included inside tb_pmp_unit, which
// supplies the pmp_pkg import. Grain is 4 bytes, as in the DUT
//**************************************************************************
`ifndef PMP_TB_REF_SVH
`define PMP_TB_REF_SVH

pmp_cfg_array_t  ref_cfg;   // Shadow of the DUT registers
pmp_addr_array_t ref_addr;

function automatic logic is_cfg_csr(logic [11:0] a);
  return (a >= PMP_CFG_BASE) && (a < PMP_CFG_BASE + 12'd4);
endfunction

function automatic logic is_addr_csr(logic [11:0] a);
  return (a >= PMP_ADDR_BASE) && (a < PMP_ADDR_BASE + 12'd16);
endfunction

function automatic logic [31:0] ref_csr_read(logic [11:0] a);
  logic [31:0] val;
  int          base;
  val = '0;
  if (is_cfg_csr(a)) begin
    base = 4 * int'(a - PMP_CFG_BASE);
    for (int i = 0; i < 4; i++) begin
      val[8*i +: 8] = ref_cfg[base + i];
    end
  end else if (is_addr_csr(a)) begin
    val = ref_addr[int'(a - PMP_ADDR_BASE)];
  end
  return val;
endfunction

function automatic void ref_csr_write(logic [11:0] a, logic [31:0] data);
  pmpcfg_t byte_val;
  int      e;
  logic    above_locked;
  if (is_cfg_csr(a)) begin
    for (int i = 0; i < 4; i++) begin
      e                 = 4 * int'(a - PMP_CFG_BASE) + i;
      byte_val          = pmpcfg_t'(data[8*i +: 8]);
      byte_val.reserved = 2'b00;
      if (!byte_val.R) begin
        byte_val.W = 1'b0;   // W without R is not allowed
      end
      if (!ref_cfg[e].L) begin
        ref_cfg[e] = byte_val;
      end
    end
  end else if (is_addr_csr(a)) begin
    e            = int'(a - PMP_ADDR_BASE);
    above_locked = 1'b0;
    if (e < PMP_ENTRIES - 1) begin
      above_locked = ref_cfg[e+1].L && (ref_cfg[e+1].A == TOR);
    end
    if (!ref_cfg[e].L && !above_locked) begin
      ref_addr[e] = data;
    end
  end
endfunction

function automatic logic ref_match(logic [31:0] word, int e);
  logic [31:0] lo;
  int          t;
  lo = (e == 0) ? 32'd0 : ref_addr[e-1];
  case (ref_cfg[e].A)
    TOR:   return (word >= lo) && (word < ref_addr[e]);
    NA4:   return word == ref_addr[e];
    NAPOT: begin
      t = 0;
      while (t < 32 && ref_addr[e][t]) begin
        t++;
      end
      if (t >= 31) begin
        return 1'b1;          // Region covers the whole space
      end
      return (word >> (t + 1)) == (ref_addr[e] >> (t + 1));
    end
    default: return 1'b0;
  endcase
endfunction

function automatic pmp_fault_t ref_fault(pmp_access_t acc, pmp_priv_t p, logic fetch);
  pmp_fault_t f;
  pmpcfg_t    c;
  logic       found;
  logic       chk;
  found = 1'b0;
  c     = '0;
  for (int e = 0; e < PMP_ENTRIES && !found; e++) begin
    if (ref_match(acc.addr >> 2, e)) begin
      found = 1'b1;
      c     = ref_cfg[e];
    end
  end
  chk = !p.m_mode || (!fetch && p.mprv && (p.mpp != PRIV_M));
  if (chk) begin
    f.load  = acc.rd && (!found || !c.R);
    f.store = acc.wr && (!found || !c.W);
    f.fetch = acc.ex && (!found || !c.X);
  end else begin
    // M mode only sees locked entries
    f.load  = acc.rd && found && c.L && !c.R;
    f.store = acc.wr && found && c.L && !c.W;
    f.fetch = acc.ex && found && c.L && !c.X;
  end
  return f;
endfunction

`endif

/* dv/tb_pmp_unit.sv */
//**************************************************************************
// Testbench for pmp_unit. Outputs are compared on the falling edge against
// a shadow model that takes each CSR write in step with the DUT
//**************************************************************************
`timescale 1ns/10ps

module tb_pmp_unit import pmp_pkg::*; ();

  localparam int N_RAND      = 300;
  localparam int TEST_CYCLES = N_RAND + 300;  // Directed phases need under 300
  localparam int MARGIN      = 100;

  logic         CLK;
  logic         nRST;
  pmp_csr_req_t csr;
  pmp_priv_t    priv;
  pmp_access_t  dacc;
  pmp_access_t  iacc;
  logic [31:0]  csr_rdata;
  logic         csr_hit;
  pmp_fault_t   dfault;
  pmp_fault_t   ifault;
  integer       seed;
  int           errors = 0;
  int           checks = 0;
  logic [31:0]  rnd;
  logic [31:0]  probes [14];
  pmp_priv_t    privs [4];

  `include "pmp_tb_ref.svh"

  pmp_unit uut (
    .CLK         (CLK),
    .nRST        (nRST),
    .i_csr       (csr),
    .i_priv      (priv),
    .i_daccess   (dacc),
    .i_iaccess   (iacc),
    .o_csr_rdata (csr_rdata),
    .o_csr_hit   (csr_hit),
    .o_dfault    (dfault),
    .o_ifault    (ifault)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  initial begin
    #((TEST_CYCLES + MARGIN) * 20);
    $display("Run timed out after %0d cycles", TEST_CYCLES + MARGIN);
    $display("Finished with errors");
    $finish;
  end

  task automatic apply_reset();
    @(posedge CLK);
    nRST     <= 1'b0;
    csr      <= '0;
    ref_cfg  = '0;
    ref_addr = '0;
    repeat (8) @(posedge CLK);
    nRST <= 1'b1;
  endtask

  task automatic drive_csr(logic wr, logic [11:0] a, logic [31:0] d);
    pmp_csr_req_t r;
    r.valid      = 1'b1;
    r.write      = wr;
    r.addr       = a;
    r.wdata.addr = d;
    @(posedge CLK);
    csr  <= r;
    dacc <= '0;
    iacc <= '0;
  endtask

  task automatic drive_access(pmp_priv_t p, logic [31:0] da, logic rd, logic wr,
                              logic [31:0] ia, logic ex);
    @(posedge CLK);
    csr  <= '0;
    priv <= p;
    dacc <= '{addr: da, rd: rd, wr: wr, ex: 1'b0};
    iacc <= '{addr: ia, rd: 1'b0, wr: 1'b0, ex: ex};
  endtask

  always @(negedge CLK) begin : compare
    pmp_fault_t exp_d;
    pmp_fault_t exp_i;
    logic       exp_hit;
    if (nRST) begin
      exp_d   = ref_fault(dacc, priv, 1'b0);
      exp_i   = ref_fault(iacc, priv, 1'b1);
      exp_hit = is_cfg_csr(csr.addr) || is_addr_csr(csr.addr);
      checks++;
      if (dfault !== exp_d) begin
        errors++;
        $display("CHECK FAILED %0t: dfault %b expected %b (addr %h priv %b)",
                 $time, dfault, exp_d, dacc.addr, priv);
      end
      if (ifault !== exp_i) begin
        errors++;
        $display("CHECK FAILED %0t: ifault %b expected %b (addr %h priv %b)",
                 $time, ifault, exp_i, iacc.addr, priv);
      end
      if (csr_hit !== exp_hit || csr_rdata !== ref_csr_read(csr.addr)) begin
        errors++;
        $display("CHECK FAILED %0t: csr %h read %h hit %b expected %h hit %b",
                 $time, csr.addr, csr_rdata, csr_hit, ref_csr_read(csr.addr), exp_hit);
      end
      if (csr.valid && csr.write) begin
        ref_csr_write(csr.addr, csr.wdata.addr);   // DUT takes it on the next edge
      end
    end
  end

  initial begin
    seed     = 32'h8c71_a27c;
    nRST     = 1'b0;
    csr      = '0;
    priv     = '0;
    dacc     = '0;
    iacc     = '0;
    ref_cfg  = '0;
    ref_addr = '0;
    probes   = '{32'h0000, 32'h03FC, 32'h0400, 32'h0404, 32'h07FC, 32'h0800, 32'h1000,
                 32'h1004, 32'h1FFC, 32'h2000, 32'h27FC, 32'h2800, 32'h2FFC, 32'h3000};
    // U mode, plain M, M with MPRV to U, M with MPRV to M
    privs    = '{4'b0000, 4'b1000, 4'b1100, 4'b1111};
    repeat (8) @(posedge CLK);
    nRST <= 1'b1;

    // Reset values and CSR decode
    for (int i = 0; i < 4; i++) drive_csr(1'b0, PMP_CFG_BASE + 12'(i), '0);
    for (int i = 0; i < 16; i++) drive_csr(1'b0, PMP_ADDR_BASE + 12'(i), '0);
    drive_csr(1'b0, 12'h300, '0);
    drive_csr(1'b0, 12'h3C0, '0);
    drive_access(4'b0000, 32'h100, 1'b1, 1'b0, 32'h100, 1'b1);
    drive_access(4'b1000, 32'h100, 1'b1, 1'b0, 32'h100, 1'b1);

    // WARL on random cfg words
    for (int i = 0; i < 16; i++) begin
      drive_csr(1'b1, PMP_CFG_BASE + 12'(i % 4), $random(seed));
      drive_csr(1'b0, PMP_CFG_BASE + 12'(i % 4), '0);
    end
    apply_reset();

    // Entry 1 NA4 RW, entry 2 TOR R locked
    drive_csr(1'b1, PMP_ADDR_BASE + 12'd1, 32'h100);
    drive_csr(1'b1, PMP_ADDR_BASE + 12'd2, 32'h200);
    drive_csr(1'b1, PMP_CFG_BASE, 32'h0089_1300);
    drive_csr(1'b1, PMP_CFG_BASE, 32'h0000_1300);      // Entry 2 byte must hold
    drive_csr(1'b1, PMP_ADDR_BASE + 12'd2, 32'h300);   // Locked
    drive_csr(1'b1, PMP_ADDR_BASE + 12'd1, 32'h050);   // Base of locked TOR
    drive_csr(1'b1, PMP_ADDR_BASE, 32'h040);
    for (int i = 0; i < 4; i++) drive_csr(1'b0, PMP_ADDR_BASE + 12'(i), '0);
    drive_csr(1'b0, PMP_CFG_BASE, '0);

    // NA4 X at 0x1000, NAPOT R over 0x2000..0x2FFF, TOR RWX overlapping it
    drive_csr(1'b1, PMP_ADDR_BASE + 12'd4, 32'h400);
    drive_csr(1'b1, PMP_ADDR_BASE + 12'd5, 32'h9FF);
    drive_csr(1'b1, PMP_ADDR_BASE + 12'd6, 32'hC00);
    drive_csr(1'b1, PMP_CFG_BASE + 12'd1, 32'h000F_1914);
    foreach (privs[p]) begin
      foreach (probes[k]) begin
        drive_access(privs[p], probes[k], 1'b1, 1'b1, probes[k], 1'b1);
      end
    end

    // Random entries inside the first 4 KB, then random accesses there
    apply_reset();
    for (int i = 0; i < 16; i++) begin
      drive_csr(1'b1, PMP_ADDR_BASE + 12'(i), $random(seed) & 32'h3FF);
    end
    for (int i = 0; i < 4; i++) drive_csr(1'b1, PMP_CFG_BASE + 12'(i), $random(seed));
    for (int i = 0; i < N_RAND; i++) begin
      rnd = $random(seed);
      drive_access(pmp_priv_t'(rnd[15:12]), {20'h0, rnd[11:2], 2'b00}, rnd[16], rnd[17],
                   {20'h0, rnd[29:20], 2'b00}, rnd[18]);
    end

    drive_access('0, '0, 1'b0, 1'b0, '0, 1'b0);
    repeat (2) @(posedge CLK);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+dv
verilog/pmp_pkg.sv
verilog/pmp_matcher.sv
verilog/pmp_checker.sv
verilog/pmp_csr_file.sv
verilog/pmp_unit.sv
dv/tb_pmp_unit.sv

/* Makefile */
# Verilator build and run for the PMP unit; all variables can be overridden
VERILATOR  ?= verilator
TOP        ?= tb_pmp_unit
RTL_TOP    ?= pmp_unit
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
BUILD_OPTS ?= --binary -j 0 -Wno-fatal
LINT_OPTS  ?= --lint-only -Wall --timing
PASS_MSG   ?= Finished with no errors

.PHONY: all run lint clean

all: run

run:
	$(VERILATOR) $(BUILD_OPTS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_OPTS) -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
